/* Makefile */
VERILATOR ?= verilator
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TOP       ?= tb_ex_stage
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

SRCS := $(shell grep -v '^+' files.f) $(wildcard hdl/*.svh bench/*.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) files.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f files.f

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@if grep -q "=== PASS ===" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/ex_ref.svh */
`ifndef EX_REF_SVH
`define EX_REF_SVH

// expected value of every ex_stage output
typedef struct packed {
    word_t     reg_wdata;
    logic      reg_we;
    reg_addr_t reg_waddr;
    word_t     mem_addr;
    word_t     mem_wdata;
    logic      mem_we;
    logic      mem_req;
    logic      ready;
    logic      jump_flag;
    word_t     jump_addr;
} expect_t;

function automatic word_t ref_alu(input word_t inst, input word_t a, input word_t b,
                                  input cmp_t cmp);
    logic [6:0]             opc;
    logic                   is_op;
    logic [`EX_SHAMT_W-1:0] sh;
    opc   = inst[6:0];
    is_op = (opc == OP);
    if (opc == LUI || opc == AUIPC)
        return a + b;
    if (!(opc == OP_IMM || is_op))
        return '0;
    if (is_op && inst[31:25] != 7'h00 && inst[31:25] != 7'h20)
        return '0;   // unknown funct7
    sh = is_op ? b[`EX_SHAMT_W-1:0] : inst[24:20];
    case (inst[14:12])
        3'd0:    return (is_op && inst[30]) ? a - b : a + b;
        3'd1:    return a << sh;
        3'd2:    return {31'b0, ~cmp.ge_s};
        3'd3:    return {31'b0, ~cmp.ge_u};
        3'd4:    return a ^ b;
        // sign fill by mask
        3'd5:    return (a >> sh) | ((inst[30] && a[31]) ? ~(32'hffff_ffff >> sh) : 32'h0);
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

function automatic word_t ref_load(input word_t inst, input word_t addr, input word_t rdata);
    logic [7:0]  byte_v;
    logic [15:0] half_v;
    if (inst[6:0] != LOAD)
        return '0;
    byte_v = 8'(rdata >> (8 * addr[1:0]));
    half_v = 16'(rdata >> (16 * addr[1]));
    case (inst[14:12])
        3'd0:    return {{24{byte_v[7]}}, byte_v};
        3'd1:    return {{16{half_v[15]}}, half_v};
        3'd2:    return rdata;
        3'd4:    return {24'b0, byte_v};
        3'd5:    return {16'b0, half_v};
        default: return '0;
    endcase
endfunction

function automatic word_t ref_store(input word_t inst, input word_t addr, input word_t sd,
                                    input word_t rdata);
    word_t mask;
    word_t data;
    if (inst[6:0] != STORE)
        return '0;
    case (inst[14:12])
        3'd0: begin
            mask = 32'hff << (8 * addr[1:0]);
            data = {4{sd[7:0]}};
        end
        3'd1: begin
            mask = 32'hffff << (16 * addr[1]);
            data = {2{sd[15:0]}};
        end
        3'd2:    return sd;
        default: return '0;
    endcase
    return (rdata & ~mask) | (data & mask);
endfunction

function automatic expect_t ref_model(
    input word_t inst, input word_t next_pc, input logic we, input reg_addr_t waddr,
    input word_t a, input word_t b, input cmp_t cmp, input word_t sd,
    input logic irq, input word_t irq_addr, input word_t rdata, input logic mready);
    expect_t    e;
    logic [6:0] opc;
    word_t      addr;
    logic       is_mem;
    logic       taken;
    word_t      link;
    opc         = inst[6:0];
    addr        = a + b;
    is_mem      = (opc == LOAD) || (opc == STORE);
    taken       = 1'b0;
    link        = '0;
    e.jump_addr = '0;
    case (opc)
        BRANCH: begin
            case (inst[14:12])
                3'b000:  taken = cmp.eq;
                3'b001:  taken = !cmp.eq;
                3'b100:  taken = !cmp.ge_s;
                3'b101:  taken = cmp.ge_s;
                3'b110:  taken = !cmp.ge_u;
                3'b111:  taken = cmp.ge_u;
                default: taken = 1'b0;
            endcase
            if (taken)
                e.jump_addr = addr;
        end
        JAL, JALR: begin
            taken       = 1'b1;
            e.jump_addr = addr;
            link        = next_pc;
        end
        FENCE: begin
            taken       = 1'b1;
            e.jump_addr = next_pc;
        end
        default: ;
    endcase
    e.reg_wdata = ref_alu(inst, a, b, cmp) | ref_load(inst, addr, rdata) | link;
    e.reg_we    = we && !irq;
    e.reg_waddr = waddr;
    e.mem_addr  = is_mem ? addr : '0;
    e.mem_wdata = ref_store(inst, addr, sd, rdata);
    e.mem_we    = (opc == STORE) && !irq;
    e.mem_req   = is_mem && !irq;
    e.ready     = !(is_mem && !mready);   // stall ignores the interrupt
    e.jump_flag = taken || irq;
    if (irq)
        e.jump_addr = irq_addr;
    return e;
endfunction

task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1);
endtask

task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
        $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
        $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
        abort_run();
    end
endtask

`endif

/* bench/tb_ex_stage.sv */
`timescale 1ns/1ns
`include "ex_defines.svh"

module tb_ex_stage
    import ex_pkg::*;
();

    localparam int N_RAND      = 400;
    localparam int N_STALL     = 8;
    localparam int STALL_LIMIT = 16;

    logic       clk_i;
    logic       rst_i;
    word_t      inst_i;
    word_t      inst_addr_next_i;
    logic       reg_we_i;
    reg_addr_t  reg_waddr_i;
    word_t      op1_i;
    word_t      op2_i;
    cmp_t       compare_i;
    word_t      store_data_i;
    logic       int_assert_i;
    word_t      int_addr_i;
    word_t      mem_rdata_i;
    logic       mem_ready_i;
    word_t      mem_wdata_o;
    word_t      mem_addr_o;
    logic       mem_we_o;
    logic       mem_req_o;
    word_t      reg_wdata_o;
    logic       reg_we_o;
    reg_addr_t  reg_waddr_o;
    logic       ready_o;
    logic       jump_flag_o;
    word_t      jump_addr_o;

    logic       check_en;
    logic [6:0] opcodes [10];
    int         n;
    int         hold;
    int         waited;

    `include "ex_ref.svh"

    ex_stage ex_stage_i (.*);

    always #2 clk_i = ~clk_i;

    // fresh random inputs for one opcode and an optional byte lane
    task automatic randomize_inputs(input logic [6:0] opc, input logic irq, input int lane);
        word_t raw;
        raw = $urandom;
        if (opc == OP && $urandom_range(0, 7) != 0)
            raw[31:25] = {1'b0, raw[30], 5'b0};   // mostly legal funct7
        inst_i = {raw[31:7], opc};
        op1_i  = $urandom;
        op2_i  = ($urandom_range(0, 3) == 0) ? op1_i : $urandom;
        if (lane >= 0)   // negative lane leaves the address free
            op2_i[1:0] = 2'(lane) - op1_i[1:0];
        // flags as decode would build them
        compare_i.eq     = (op1_i == op2_i);
        compare_i.ge_u   = (op1_i >= op2_i);
        compare_i.ge_s   = ($signed(op1_i) >= $signed(op2_i));
        inst_addr_next_i = $urandom;
        reg_we_i         = 1'($urandom_range(0, 1));
        reg_waddr_i      = 5'($urandom);
        store_data_i     = $urandom;
        mem_rdata_i      = $urandom;
        mem_ready_i      = 1'b1;
        int_assert_i     = irq;
        int_addr_i       = $urandom;
    endtask

    task automatic compare_outputs();
        expect_t e;
        e = ref_model(inst_i, inst_addr_next_i, reg_we_i, reg_waddr_i, op1_i, op2_i,
                      compare_i, store_data_i, int_assert_i, int_addr_i, mem_rdata_i,
                      mem_ready_i);
        check_word("reg_wdata_o", reg_wdata_o, e.reg_wdata);
        check_flag("reg_we_o", reg_we_o, e.reg_we);
        check_addr("reg_waddr_o", reg_waddr_o, e.reg_waddr);
        check_word("mem_addr_o", mem_addr_o, e.mem_addr);
        check_word("mem_wdata_o", mem_wdata_o, e.mem_wdata);
        check_flag("mem_we_o", mem_we_o, e.mem_we);
        check_flag("mem_req_o", mem_req_o, e.mem_req);
        check_flag("ready_o", ready_o, e.ready);
        check_flag("jump_flag_o", jump_flag_o, e.jump_flag);
        check_word("jump_addr_o", jump_addr_o, e.jump_addr);
    endtask

    // rising edges until ready_o is high
    task automatic wait_ready(input int limit, output int cycles);
        @(posedge clk_i);
        cycles = 1;
        while (!ready_o) begin
            if (cycles >= limit) begin
                $display("stall did not end: ready_o still low after %0d cycles", limit);
                abort_run();
            end
            @(posedge clk_i);
            cycles++;
        end
    endtask

    always @(posedge clk_i) begin
        if (check_en)
            compare_outputs();
    end

    initial begin
        void'($urandom(32'hd7aa_e3bc));
        opcodes = '{OP_IMM, OP, LOAD, STORE, BRANCH, JAL, JALR, LUI, AUIPC, FENCE};
        clk_i            = 1'b0;
        rst_i            = 1'b1;
        check_en         = 1'b0;
        inst_i           = '0;
        inst_addr_next_i = '0;
        reg_we_i         = 1'b0;
        reg_waddr_i      = '0;
        op1_i            = '0;
        op2_i            = '0;
        compare_i        = '0;
        store_data_i     = '0;
        int_assert_i     = 1'b0;
        int_addr_i       = '0;
        mem_rdata_i      = '0;
        mem_ready_i      = 1'b1;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_i    = 1'b0;
        check_en = 1'b1;

        for (n = 0; n < N_RAND; n++) begin   // register and immediate alu ops
            @(negedge clk_i);
            randomize_inputs(n[0] ? OP : OP_IMM, 1'b0, -1);
        end

        for (n = 0; n < N_RAND; n++) begin   // all four lanes for both directions
            @(negedge clk_i);
            randomize_inputs(n[0] ? STORE : LOAD, 1'b0, (n / 2) % 4);
        end

        for (n = 0; n < N_RAND; n++) begin   // branch, jal, jalr, lui, auipc, fence
            @(negedge clk_i);
            randomize_inputs(opcodes[4'(4 + n % 6)], 1'b0, -1);
        end

        for (n = 0; n < N_STALL; n++) begin
            @(negedge clk_i);
            randomize_inputs(LOAD, 1'b0, -1);
            mem_ready_i = 1'b0;
            hold        = $urandom_range(1, 8);
            repeat (hold) begin
                @(posedge clk_i);
                check_flag("ready_o", ready_o, 1'b0);
            end
            @(negedge clk_i);
            mem_ready_i = 1'b1;
            wait_ready(STALL_LIMIT, waited);
            if (waited != 1) begin
                $display("ready_o rose %0d cycles after mem_ready_i instead of at once",
                         waited - 1);
                abort_run();
            end
        end

        for (n = 0; n < N_RAND; n++) begin   // interrupt over any opcode
            @(negedge clk_i);
            randomize_inputs(opcodes[4'($urandom_range(0, 9))], 1'b1, -1);
        end

        @(negedge clk_i);
        check_en = 1'b0;
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* files.f */
+incdir+hdl
+incdir+bench
hdl/ex_pkg.sv
hdl/ex_alu.sv
hdl/ex_lsu.sv
hdl/ex_branch.sv
hdl/ex_stage.sv
bench/tb_ex_stage.sv

/* hdl/ex_alu.sv */
`timescale 1ns/1ns
`include "ex_defines.svh"

module ex_alu
    import ex_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    input  word_t inst_i,
    input  word_t op1_i,
    input  word_t op2_i,
    input  cmp_t  compare_i,
    output word_t alu_wdata_o
);

    opcode_e                opcode;
    alu_f3_e                funct3;
    logic [6:0]             funct7;
    logic [`EX_SHAMT_W-1:0] shamt;
    logic                   is_imm;
    logic                   f7_ok;
    word_t                  sum;

    always_comb begin
        opcode = opcode_e'(inst_i[`EX_OPCODE_MSB:`EX_OPCODE_LSB]);
        funct3 = alu_f3_e'(inst_i[`EX_FUNCT3_MSB:`EX_FUNCT3_LSB]);
        funct7 = inst_i[`EX_FUNCT7_MSB:`EX_FUNCT7_LSB];
    end

    assign is_imm = (opcode == OP_IMM);
    // immediate forms carry no funct7
    assign f7_ok  = is_imm || (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
    assign shamt  = is_imm ? inst_i[`EX_SHAMT_LSB+`EX_SHAMT_W-1:`EX_SHAMT_LSB]
                           : op2_i[`EX_SHAMT_W-1:0];
    assign sum    = op1_i + op2_i;

    always_comb begin
        alu_wdata_o = '0;
        case (opcode)
            OP_IMM, OP: begin
                if (f7_ok) begin
                    case (funct3)
                        F3_ADD_SUB: begin
                            if (!is_imm && inst_i[`EX_ALT_BIT])
                                alu_wdata_o = op1_i - op2_i;
                            else
                                alu_wdata_o = sum;
                        end
                        F3_SLL:  alu_wdata_o = op1_i << shamt;
                        F3_SLT:  alu_wdata_o = {{(`EX_XLEN-1){1'b0}}, ~compare_i.ge_s};
                        F3_SLTU: alu_wdata_o = {{(`EX_XLEN-1){1'b0}}, ~compare_i.ge_u};
                        F3_XOR:  alu_wdata_o = op1_i ^ op2_i;
                        F3_SR: begin
                            if (inst_i[`EX_ALT_BIT])
                                alu_wdata_o = word_t'($signed(op1_i) >>> shamt);  // sra
                            else
                                alu_wdata_o = op1_i >> shamt;
                        end
                        F3_OR:   alu_wdata_o = op1_i | op2_i;
                        F3_AND:  alu_wdata_o = op1_i & op2_i;
                        default: alu_wdata_o = '0;
                    endcase
                end
            end
            LUI, AUIPC: alu_wdata_o = sum;   // decode already picked op1
            default:    alu_wdata_o = '0;
        endcase
    end

    // other units own the write value outside these opcodes
    a_alu_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
        !(opcode inside {OP_IMM, OP, LUI, AUIPC}) |-> (alu_wdata_o == '0));

endmodule

/* hdl/ex_branch.sv */
`timescale 1ns/1ns
`include "ex_defines.svh"

module ex_branch
    import ex_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    input  word_t inst_i,
    input  word_t op1_i,
    input  word_t op2_i,
    input  word_t inst_addr_next_i,
    input  cmp_t  compare_i,
    output logic  jump_flag_o,
    output word_t jump_addr_o,
    output word_t link_wdata_o
);

    opcode_e    opcode;
    branch_f3_e funct3;
    word_t      target;

    always_comb begin
        opcode = opcode_e'(inst_i[`EX_OPCODE_MSB:`EX_OPCODE_LSB]);
        funct3 = branch_f3_e'(inst_i[`EX_FUNCT3_MSB:`EX_FUNCT3_LSB]);
    end

    assign target = op1_i + op2_i;   // pc + offset or rs1 + offset

    always_comb begin
        jump_flag_o  = 1'b0;
        jump_addr_o  = '0;
        link_wdata_o = '0;
        case (opcode)
            BRANCH: begin
                case (funct3)
                    F3_BEQ:  jump_flag_o = compare_i.eq;
                    F3_BNE:  jump_flag_o = ~compare_i.eq;
                    F3_BLT:  jump_flag_o = ~compare_i.ge_s;
                    F3_BGE:  jump_flag_o = compare_i.ge_s;
                    F3_BLTU: jump_flag_o = ~compare_i.ge_u;
                    F3_BGEU: jump_flag_o = compare_i.ge_u;
                    default: jump_flag_o = 1'b0;
                endcase
                jump_addr_o = jump_flag_o ? target : '0;
            end
            JAL, JALR: begin
                jump_flag_o  = 1'b1;
                jump_addr_o  = target;
                link_wdata_o = inst_addr_next_i;
            end
            FENCE: begin
                jump_flag_o = 1'b1;    // refetch from the next address
                jump_addr_o = inst_addr_next_i;
            end
            default: ;
        endcase
    end

    a_addr_idle: assert property (@(posedge clk_i) disable iff (rst_i)
        !jump_flag_o |-> (jump_addr_o == '0));

endmodule

/* hdl/ex_defines.svh */
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// datapath widths
`define EX_XLEN        32
`define EX_REG_ADDR_W  5
`define EX_SHAMT_W     5

// rv32 instruction fields
`define EX_OPCODE_MSB  6
`define EX_OPCODE_LSB  0
`define EX_FUNCT3_MSB  14
`define EX_FUNCT3_LSB  12
`define EX_FUNCT7_MSB  31
`define EX_FUNCT7_LSB  25
`define EX_SHAMT_LSB   20   // immediate shift amount in the rs2 slot
`define EX_ALT_BIT     30   // sub / arithmetic shift select

`endif

/* hdl/ex_lsu.sv */
`timescale 1ns/1ns
`include "ex_defines.svh"

module ex_lsu
    import ex_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    input  word_t inst_i,
    input  word_t op1_i,
    input  word_t op2_i,
    input  word_t store_data_i,
    input  word_t mem_rdata_i,
    input  logic  mem_ready_i,
    output word_t load_wdata_o,
    output word_t mem_addr_o,
    output word_t mem_wdata_o,
    output logic  mem_we_o,
    output logic  mem_req_o,
    output logic  ready_o
);

    opcode_e    opcode;
    load_f3_e   load_f3;
    store_f3_e  store_f3;
    word_t      addr;
    logic [1:0] lane;
    logic       is_load;
    logic       is_store;
    logic [7:0] rd_byte;
    logic [15:0] rd_half;
    word_t      merged;

    always_comb begin
        opcode   = opcode_e'(inst_i[`EX_OPCODE_MSB:`EX_OPCODE_LSB]);
        load_f3  = load_f3_e'(inst_i[`EX_FUNCT3_MSB:`EX_FUNCT3_LSB]);
        store_f3 = store_f3_e'(inst_i[`EX_FUNCT3_MSB:`EX_FUNCT3_LSB]);
    end

    assign addr     = op1_i + op2_i;
    assign lane     = addr[1:0];    // no alignment forced
    assign is_load  = (opcode == LOAD);
    assign is_store = (opcode == STORE);

    assign mem_req_o  = is_load | is_store;
    assign mem_we_o   = is_store;
    assign mem_addr_o = mem_req_o ? addr : '0;
    assign ready_o    = ~(mem_req_o & ~mem_ready_i);   // stall until memory answers

    // addressed lanes of the read word
    always_comb begin
        case (lane)
            2'd0:    rd_byte = mem_rdata_i[7:0];
            2'd1:    rd_byte = mem_rdata_i[15:8];
            2'd2:    rd_byte = mem_rdata_i[23:16];
            default: rd_byte = mem_rdata_i[31:24];
        endcase
        rd_half = lane[1] ? mem_rdata_i[31:16] : mem_rdata_i[15:0];
    end

    always_comb begin
        load_wdata_o = '0;
        if (is_load) begin
            case (load_f3)
                F3_LB:   load_wdata_o = {{(`EX_XLEN-8){rd_byte[7]}}, rd_byte};
                F3_LH:   load_wdata_o = {{(`EX_XLEN-16){rd_half[15]}}, rd_half};
                F3_LW:   load_wdata_o = mem_rdata_i;
                F3_LBU:  load_wdata_o = {{(`EX_XLEN-8){1'b0}}, rd_byte};
                F3_LHU:  load_wdata_o = {{(`EX_XLEN-16){1'b0}}, rd_half};
                default: load_wdata_o = '0;
            endcase
        end
    end

    // read-merge for sub-word stores
    always_comb begin
        merged = mem_rdata_i;
        case (store_f3)
            F3_SB:   merged[lane*8 +: 8] = store_data_i[7:0];
            F3_SH:   merged[lane[1]*16 +: 16] = store_data_i[15:0];
            F3_SW:   merged = store_data_i;
            default: merged = '0;
        endcase
        mem_wdata_o = is_store ? merged : '0;
    end

    a_we_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
        mem_we_o |-> mem_req_o);
    a_stall_on_req: assert property (@(posedge clk_i) disable iff (rst_i)
        !ready_o |-> mem_req_o);

endmodule

/* hdl/ex_pkg.sv */
`include "ex_defines.svh"

package ex_pkg;

    typedef logic [`EX_XLEN-1:0]       word_t;
    typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;

    // compare flags from decode with eq in bit 0
    typedef struct packed {
        logic ge_s;
        logic ge_u;
        logic eq;
    } cmp_t;

    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        FENCE  = 7'b0001111
    } opcode_e;

    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SR      = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } alu_f3_e;

    typedef enum logic [2:0] {
        F3_LB  = 3'b000,
        F3_LH  = 3'b001,
        F3_LW  = 3'b010,
        F3_LBU = 3'b100,
        F3_LHU = 3'b101
    } load_f3_e;

    typedef enum logic [2:0] {
        F3_SB = 3'b000,
        F3_SH = 3'b001,
        F3_SW = 3'b010
    } store_f3_e;

    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } branch_f3_e;

endpackage

/* hdl/ex_stage.sv */
`timescale 1ns/1ns
`include "ex_defines.svh"

module ex_stage
    import ex_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,

    // from decode
    input  word_t     inst_i,
    input  word_t     inst_addr_next_i,
    input  logic      reg_we_i,
    input  reg_addr_t reg_waddr_i,
    input  word_t     op1_i,
    input  word_t     op2_i,
    input  cmp_t      compare_i,
    input  word_t     store_data_i,
    input  logic      int_assert_i,
    input  word_t     int_addr_i,

    // memory
    input  word_t     mem_rdata_i,
    input  logic      mem_ready_i,
    output word_t     mem_wdata_o,
    output word_t     mem_addr_o,
    output logic      mem_we_o,
    output logic      mem_req_o,

    // register file
    output word_t     reg_wdata_o,
    output logic      reg_we_o,
    output reg_addr_t reg_waddr_o,

    // control
    output logic      ready_o,
    output logic      jump_flag_o,
    output word_t     jump_addr_o
);

    word_t alu_wdata;
    word_t load_wdata;
    word_t link_wdata;
    logic  mem_we;
    logic  mem_req;
    logic  jump_flag;
    word_t jump_addr;

    ex_alu ex_alu_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .inst_i      (inst_i),
        .op1_i       (op1_i),
        .op2_i       (op2_i),
        .compare_i   (compare_i),
        .alu_wdata_o (alu_wdata)
    );

    ex_lsu ex_lsu_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .inst_i       (inst_i),
        .op1_i        (op1_i),
        .op2_i        (op2_i),
        .store_data_i (store_data_i),
        .mem_rdata_i  (mem_rdata_i),
        .mem_ready_i  (mem_ready_i),
        .load_wdata_o (load_wdata),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_we_o     (mem_we),
        .mem_req_o    (mem_req),
        .ready_o      (ready_o)   // stall is not masked by the interrupt
    );

    ex_branch ex_branch_i (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .inst_i           (inst_i),
        .op1_i            (op1_i),
        .op2_i            (op2_i),
        .inst_addr_next_i (inst_addr_next_i),
        .compare_i        (compare_i),
        .jump_flag_o      (jump_flag),
        .jump_addr_o      (jump_addr),
        .link_wdata_o     (link_wdata)
    );

    // units zero their value when the opcode is not theirs
    assign reg_wdata_o = alu_wdata | load_wdata | link_wdata;
    assign reg_waddr_o = reg_waddr_i;

    // interrupt takes over the redirect and blocks side effects
    assign reg_we_o    = int_assert_i ? 1'b0 : reg_we_i;
    assign mem_we_o    = int_assert_i ? 1'b0 : mem_we;
    assign mem_req_o   = int_assert_i ? 1'b0 : mem_req;
    assign jump_flag_o = jump_flag | int_assert_i;
    assign jump_addr_o = int_assert_i ? int_addr_i : jump_addr;

    a_one_writer: assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0({|alu_wdata, |load_wdata, |link_wdata}));

endmodule
